// ==== Makefile ====
VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= dsp_core_tb
RTL_TOP   ?= dsp_core
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP)

sim: $(OBJ_DIR)/$(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/dsp_config.svh ====
`ifndef DSP_CONFIG_SVH
`define DSP_CONFIG_SVH

// Data path widths
`define DSP_DATA_W  16
`define DSP_ACC_W   36          // Room for guard bits above the 32-bit product

// Program memory, 64 words
`define DSP_PROG_AW 6

// Data RAM, 64 words
`define DSP_RAM_AW  6

// Y unit pointer registers r0..r3
`define DSP_NPTR    4

// Instruction word width, fixed by the encoding
`define DSP_INSTR_W 16

`endif

// ==== design/dsp_core.sv ====
`timescale 1ns/1ps
`include "dsp_config.svh"

module dsp_core
    import dsp_isa_pkg::*;
    import dsp_host_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  prog_req,
    input  prog_load_t            prog_word,
    output logic                  prog_ack,
    input  logic                  run_req,
    output logic                  run_ack,
    output logic [`DSP_ACC_W-1:0] acc,
    output logic                  fault
);

    logic                   fetch_valid;
    instr_t                 fetch_word;
    logic                   run_start;
    ctrl_t                  ctrl;
    logic [`DSP_RAM_AW-1:0] ram_addr;
    logic [`DSP_DATA_W-1:0] ram_rdata;

    dsp_sequencer u_seq (
        .clk, .rst, .prog_req, .prog_word, .prog_ack, .run_req, .run_ack,
        .fetch_valid, .fetch_word, .halt(ctrl.halt), .run_start
    );

    dsp_decoder u_dec (
        .clk, .rst, .run_start, .fetch_valid, .fetch_word, .ctrl, .fault
    );

    dsp_yaau u_yaau (.clk, .rst, .ctrl, .ram_addr);

    dsp_dau u_dau (.clk, .rst, .ctrl, .ram_rdata, .acc);

    // Address from the Y unit, write data from the arithmetic unit
    dsp_data_ram u_ram (.clk, .ctrl, .ram_addr, .acc, .ram_rdata);

endmodule

// ==== design/dsp_data_ram.sv ====
`timescale 1ns/1ps
`include "dsp_config.svh"

module dsp_data_ram
    import dsp_isa_pkg::*;
(
    input  logic                   clk,
    input  ctrl_t                  ctrl,
    input  logic [`DSP_RAM_AW-1:0] ram_addr,
    input  logic [`DSP_ACC_W-1:0]  acc,
    output logic [`DSP_DATA_W-1:0] ram_rdata
);

    logic [`DSP_DATA_W-1:0] mem [2**`DSP_RAM_AW];
    logic [`DSP_DATA_W-1:0] imm_ext;
    logic [`DSP_DATA_W-1:0] wdata;

    // STI byte sits in imm[9:2]
    assign imm_ext = {{(`DSP_DATA_W-8){ctrl.imm[9]}}, ctrl.imm[9:2]};
    assign wdata   = ctrl.sel_imm ? imm_ext : acc[`DSP_DATA_W-1:0];

    assign ram_rdata = mem[ram_addr];   // Same cycle read for LDX/LDY

    always_ff @(posedge clk) begin
        if (ctrl.ram_we) begin
            mem[ram_addr] <= wdata;
        end
    end

endmodule

// ==== design/dsp_dau.sv ====
`timescale 1ns/1ps
`include "dsp_config.svh"

module dsp_dau
    import dsp_isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  ctrl_t                  ctrl,
    input  logic [`DSP_DATA_W-1:0] ram_rdata,
    output logic [`DSP_ACC_W-1:0]  acc
);

    localparam int PROD_W = 2 * `DSP_DATA_W;

    logic signed [`DSP_DATA_W-1:0] x_reg;
    logic signed [`DSP_DATA_W-1:0] y_reg;
    logic signed [PROD_W-1:0]      prod;

    assign prod = x_reg * y_reg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x_reg <= '0;
            y_reg <= '0;
            acc   <= '0;
        end else begin
            if (ctrl.load_x) x_reg <= ram_rdata;
            if (ctrl.load_y) y_reg <= ram_rdata;
            if (ctrl.clr) begin
                acc <= '0;
            end else if (ctrl.mac) begin
                // Product sign-extended into the guard bits
                acc <= acc + {{(`DSP_ACC_W-PROD_W){prod[PROD_W-1]}}, prod};
            end
        end
    end

    a_mac_clr_excl: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.mac && ctrl.clr));

endmodule

// ==== design/dsp_decoder.sv ====
`timescale 1ns/1ps
`include "dsp_config.svh"

module dsp_decoder
    import dsp_isa_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   run_start,
    input  logic   fetch_valid,
    input  instr_t fetch_word,
    output ctrl_t  ctrl,
    output logic   fault
);

    logic halted;   // Set by HALT so later words are dropped

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl   <= '0;
            halted <= 1'b0;
            fault  <= 1'b0;
        end else begin
            // All strobes low unless the case below sets one
            ctrl         <= '0;
            ctrl.ptr_sel <= fetch_word.ptr_sel;
            ctrl.mode    <= fetch_word.mode;
            ctrl.imm     <= {fetch_word.imm, fetch_word.mode};

            if (run_start) begin
                halted <= 1'b0;
            end else if (fetch_valid && !halted) begin
                case (fetch_word.opcode)
                    OP_NOP: begin
                    end
                    OP_SETR: ctrl.set_ptr <= 1'b1;
                    OP_SETJ: ctrl.set_j   <= 1'b1;
                    OP_LDX:  ctrl.load_x  <= 1'b1;
                    OP_LDY:  ctrl.load_y  <= 1'b1;
                    OP_STI: begin
                        ctrl.ram_we  <= 1'b1;
                        ctrl.sel_imm <= 1'b1;
                    end
                    OP_STA:  ctrl.ram_we  <= 1'b1;  // Accumulator low word
                    OP_MAC:  ctrl.mac     <= 1'b1;
                    OP_CLR:  ctrl.clr     <= 1'b1;
                    OP_HALT: begin
                        ctrl.halt <= 1'b1;
                        halted    <= 1'b1;
                    end
                    default: begin
                        // Undefined word runs as NOP
                        fault <= 1'b1;
                    end
                endcase
            end
        end
    end

    // Only one data path action per instruction
    a_action_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({ctrl.load_x, ctrl.load_y, ctrl.ram_we, ctrl.mac, ctrl.clr}));

endmodule

// ==== design/dsp_host_pkg.sv ====
`include "dsp_config.svh"

package dsp_host_pkg;

    // One program memory write from the host
    typedef struct packed {
        logic [`DSP_PROG_AW-1:0] addr;
        dsp_isa_pkg::instr_t     word;
    } prog_load_t;

    // Address width check helper for the host side
    localparam int PROG_DEPTH = 2 ** `DSP_PROG_AW;

    typedef logic [`DSP_PROG_AW-1:0] prog_addr_t;

endpackage

// ==== design/dsp_isa_pkg.sv ====
`include "dsp_config.svh"

package dsp_isa_pkg;

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_SETR = 4'd1,     // rN = imm10
        OP_SETJ = 4'd2,     // j = imm10
        OP_LDX  = 4'd3,     // x = *rN
        OP_LDY  = 4'd4,     // y = *rN
        OP_STI  = 4'd5,     // *rN = sext(imm8)
        OP_STA  = 4'd6,     // *rN = acc low word
        OP_MAC  = 4'd7,
        OP_CLR  = 4'd8,
        OP_HALT = 4'd15
    } opcode_e;

    typedef enum logic [1:0] {
        PM_PLAIN = 2'd0,    // *rN
        PM_INC   = 2'd1,    // *rN++
        PM_DEC   = 2'd2,    // *rN--
        PM_ADDJ  = 2'd3     // *rN++j
    } ptr_mode_e;

    typedef logic [$clog2(`DSP_NPTR)-1:0] ptr_sel_t;

    typedef struct packed {
        opcode_e   opcode;
        ptr_sel_t  ptr_sel;
        logic [7:0] imm;
        ptr_mode_e mode;
    } instr_t;

    typedef struct packed {
        logic      set_ptr;
        logic      set_j;
        logic      load_x;
        logic      load_y;
        logic      ram_we;
        logic      sel_imm;
        logic      mac;
        logic      clr;
        logic      halt;
        ptr_sel_t  ptr_sel;
        ptr_mode_e mode;
        logic [9:0] imm;    // Bits 9:2 double as the 8-bit store immediate
    } ctrl_t;

endpackage

// ==== design/dsp_sequencer.sv ====
`timescale 1ns/1ps
`include "dsp_config.svh"

module dsp_sequencer
    import dsp_isa_pkg::*;
    import dsp_host_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       prog_req,
    input  prog_load_t prog_word,
    output logic       prog_ack,
    input  logic       run_req,
    output logic       run_ack,
    output logic       fetch_valid,
    output instr_t     fetch_word,
    input  logic       halt,
    output logic       run_start
);

    instr_t     prog_mem [PROG_DEPTH];
    prog_addr_t pc;
    logic       busy;
    logic       run_req_q;
    logic       prog_wr;

    // Loads are refused while a program runs
    assign prog_wr   = prog_req && !prog_ack && !busy;
    assign run_start = run_req && !run_req_q && !busy;

    // Host write port and synchronous fetch
    always_ff @(posedge clk) begin
        if (prog_wr) begin
            prog_mem[prog_word.addr] <= prog_word.word;
        end
        fetch_word <= prog_mem[pc];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc          <= '0;
            busy        <= 1'b0;
            run_req_q   <= 1'b0;
            run_ack     <= 1'b0;
            prog_ack    <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            run_req_q   <= run_req;
            fetch_valid <= busy && !halt;
            if (prog_wr) begin
                prog_ack <= 1'b1;
            end else if (!prog_req) begin
                prog_ack <= 1'b0;       // Phase 4
            end
            if (run_start) begin
                pc   <= '0;
                busy <= 1'b1;
            end else if (busy && halt) begin
                busy <= 1'b0;
            end else if (busy) begin
                pc <= pc + 1'b1;
            end
            if (busy && halt) begin
                run_ack <= 1'b1;        // Result is valid from here
            end else if (!run_req) begin
                run_ack <= 1'b0;
            end
        end
    end

    a_no_ack_while_busy: assert property (@(posedge clk) disable iff (rst)
        !(run_ack && busy));

    a_no_load_while_busy: assert property (@(posedge clk) disable iff (rst)
        $rose(prog_ack) |-> !$past(busy));

endmodule

// ==== design/dsp_yaau.sv ====
`timescale 1ns/1ps
`include "dsp_config.svh"

module dsp_yaau
    import dsp_isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  ctrl_t                  ctrl,
    output logic [`DSP_RAM_AW-1:0] ram_addr
);

    logic [`DSP_RAM_AW-1:0] ptr [`DSP_NPTR];
    logic [`DSP_RAM_AW-1:0] j_step;
    logic                   access;

    assign ram_addr = ptr[ctrl.ptr_sel];    // Value before post-modify
    assign access   = ctrl.load_x || ctrl.load_y || ctrl.ram_we;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr    <= '{default: '0};
            j_step <= '0;
        end else begin
            if (ctrl.set_j) begin
                j_step <= ctrl.imm[`DSP_RAM_AW-1:0];
            end
            if (ctrl.set_ptr) begin
                ptr[ctrl.ptr_sel] <= ctrl.imm[`DSP_RAM_AW-1:0];
            end else if (access) begin
                // Wraps modulo the RAM depth
                case (ctrl.mode)
                    PM_PLAIN: ptr[ctrl.ptr_sel] <= ram_addr;
                    PM_INC:   ptr[ctrl.ptr_sel] <= ram_addr + 1'b1;
                    PM_DEC:   ptr[ctrl.ptr_sel] <= ram_addr - 1'b1;
                    PM_ADDJ:  ptr[ctrl.ptr_sel] <= ram_addr + j_step;
                    default:  ptr[ctrl.ptr_sel] <= ram_addr;
                endcase
            end
        end
    end

endmodule

// ==== flist.f ====
+incdir+design
+incdir+verification
design/dsp_isa_pkg.sv
design/dsp_host_pkg.sv
design/dsp_sequencer.sv
design/dsp_decoder.sv
design/dsp_yaau.sv
design/dsp_dau.sv
design/dsp_data_ram.sv
design/dsp_core.sv
verification/dsp_core_tb.sv

// ==== verification/dsp_core_tests.svh ====
function automatic logic [15:0] encode(input logic [3:0] op, input logic [1:0] sel,
                                       input logic [7:0] imm, input logic [1:0] mode);
    return {op, sel, imm, mode};
endfunction

// SETR and SETJ carry a ten-bit immediate
function automatic logic [15:0] imm_word(input logic [3:0] op, input logic [1:0] sel,
                                         input logic [9:0] imm);
    return {op, sel, imm};
endfunction

function automatic logic [5:0] moved_ptr(input logic [5:0] a, input logic [1:0] mode);
    case (mode)
        2'd1:    return a + 6'd1;
        2'd2:    return a - 6'd1;
        2'd3:    return a + j_m;
        default: return a;
    endcase
endfunction

// Steps the model through the queued program up to HALT
task automatic predict_program();
    logic [15:0]        w;
    logic [5:0]         a;
    logic signed [31:0] p;
    bit                 done;
    int                 i;
    done = 0;
    i    = 0;
    while (!done && i < prog_q.size()) begin
        w = prog_q[i];
        a = ptr_m[w[11:10]];
        case (w[15:12])
            4'd0: ;
            4'd1: ptr_m[w[11:10]] = w[5:0];
            4'd2: j_m = w[5:0];
            4'd3: x_m = ram_m[a];
            4'd4: y_m = ram_m[a];
            4'd5: ram_m[a] = {{8{w[9]}}, w[9:2]};
            4'd6: ram_m[a] = acc_m[15:0];
            4'd7: begin
                p     = x_m * y_m;
                acc_m = acc_m + {{4{p[31]}}, p};
            end
            4'd8:  acc_m = '0;
            4'd15: done = 1;
            default: fault_m = 1'b1;   // Behaves as NOP
        endcase
        if (w[15:12] inside {4'd3, 4'd4, 4'd5, 4'd6}) ptr_m[w[11:10]] = moved_ptr(a, w[1:0]);
        i++;
    end
endtask

task automatic execute_and_check(input string what);
    logic [`DSP_ACC_W-1:0] result;
    predict_program();
    load_program();
    run_program(result);
    compare(result, acc_m, what);
    compare(fault, fault_m, "fault flag");
endtask

task automatic test_dot_product();
    int e0 = errors;
    prog_q.delete();
    prog_q.push_back(encode(OP_CLR, 0, 0, 0));
    prog_q.push_back(imm_word(OP_SETR, 0, 10'd0));
    prog_q.push_back(imm_word(OP_SETR, 1, 10'd8));
    for (int i = 0; i < 8; i++) begin
        prog_q.push_back(encode(OP_STI, 2'(i / 4), 8'($urandom), PM_INC));
    end
    prog_q.push_back(imm_word(OP_SETR, 0, 10'd0));
    prog_q.push_back(imm_word(OP_SETR, 1, 10'd8));
    for (int i = 0; i < 4; i++) begin
        prog_q.push_back(encode(OP_LDX, 0, 0, PM_INC));
        prog_q.push_back(encode(OP_LDY, 1, 0, PM_INC));
        prog_q.push_back(encode(OP_MAC, 0, 0, 0));
    end
    prog_q.push_back(encode(OP_HALT, 0, 0, 0));
    execute_and_check("dot product accumulator");
    report_test("dot_product", e0);
endtask

task automatic test_pointer_modes();
    int e0 = errors;
    prog_q.delete();
    prog_q.push_back(encode(OP_CLR, 0, 0, 0));
    prog_q.push_back(imm_word(OP_SETJ, 0, 10'd3));
    prog_q.push_back(imm_word(OP_SETR, 2, 10'd20));
    prog_q.push_back(encode(OP_STI, 2, 8'($urandom), PM_ADDJ));   // 20 then 23
    prog_q.push_back(encode(OP_STI, 2, 8'($urandom), PM_INC));    // 23 then 24
    prog_q.push_back(encode(OP_STI, 2, 8'($urandom), PM_DEC));    // 24 then 23
    prog_q.push_back(imm_word(OP_SETR, 3, 10'd20));
    prog_q.push_back(encode(OP_LDX, 3, 0, PM_ADDJ));
    prog_q.push_back(encode(OP_LDY, 3, 0, PM_INC));
    prog_q.push_back(encode(OP_MAC, 0, 0, 0));
    prog_q.push_back(encode(OP_LDY, 3, 0, PM_PLAIN));
    prog_q.push_back(encode(OP_MAC, 0, 0, 0));
    prog_q.push_back(encode(OP_HALT, 0, 0, 0));
    execute_and_check("pointer mode products");
    report_test("pointer_modes", e0);
endtask

task automatic test_store_reuse();
    int e0 = errors;
    prog_q.delete();
    prog_q.push_back(encode(OP_CLR, 0, 0, 0));
    prog_q.push_back(imm_word(OP_SETR, 0, 10'd63));
    prog_q.push_back(encode(OP_STI, 0, 8'($urandom), PM_INC));    // Wraps to 0
    prog_q.push_back(encode(OP_STI, 0, 8'($urandom), PM_INC));
    prog_q.push_back(imm_word(OP_SETR, 1, 10'd63));
    prog_q.push_back(encode(OP_LDX, 1, 0, PM_INC));
    prog_q.push_back(encode(OP_LDY, 1, 0, PM_PLAIN));
    prog_q.push_back(encode(OP_MAC, 0, 0, 0));
    prog_q.push_back(imm_word(OP_SETR, 0, 10'd5));
    prog_q.push_back(encode(OP_STA, 0, 0, PM_PLAIN));
    prog_q.push_back(encode(OP_CLR, 0, 0, 0));
    prog_q.push_back(encode(OP_LDX, 0, 0, PM_PLAIN));
    prog_q.push_back(imm_word(OP_SETR, 2, 10'd0));
    prog_q.push_back(encode(OP_LDY, 2, 0, PM_PLAIN));
    prog_q.push_back(encode(OP_MAC, 0, 0, 0));
    prog_q.push_back(encode(OP_HALT, 0, 0, 0));
    execute_and_check("stored accumulator reuse");
    report_test("store_reuse", e0);
endtask

task automatic test_handshake();
    int e0 = errors;
    prog_q.delete();
    prog_q.push_back(encode(OP_CLR, 0, 0, 0));
    prog_q.push_back(imm_word(OP_SETR, 0, 10'd30));
    prog_q.push_back(encode(OP_STI, 0, 8'($urandom), PM_PLAIN));
    prog_q.push_back(encode(OP_LDX, 0, 0, PM_PLAIN));
    prog_q.push_back(encode(OP_LDY, 0, 0, PM_PLAIN));
    prog_q.push_back(encode(OP_MAC, 0, 0, 0));
    prog_q.push_back(encode(OP_HALT, 0, 0, 0));
    execute_and_check("first program");
    // Shorter program over the first one keeps the accumulator
    prog_q.delete();
    prog_q.push_back(imm_word(OP_SETR, 0, 10'd31));
    prog_q.push_back(encode(OP_STI, 0, 8'($urandom), PM_PLAIN));
    prog_q.push_back(encode(OP_LDX, 0, 0, PM_PLAIN));
    prog_q.push_back(encode(OP_MAC, 0, 0, 0));
    prog_q.push_back(encode(OP_HALT, 0, 0, 0));
    execute_and_check("second program without CLR");
    next_cycle();
    compare({prog_ack, run_ack}, 2'b00, "acks stay low after both runs");
    report_test("handshake", e0);
endtask

task automatic test_fault();
    int e0 = errors;
    compare(fault, 1'b0, "fault clear before bad opcode");
    prog_q.delete();
    prog_q.push_back(encode(OP_CLR, 0, 0, 0));
    prog_q.push_back(imm_word(OP_SETR, 0, 10'd40));
    prog_q.push_back(encode(OP_STI, 0, 8'($urandom), PM_INC));
    prog_q.push_back(encode(4'd9, 0, 8'h5a, PM_INC));             // Undefined opcode
    prog_q.push_back(encode(OP_STI, 0, 8'($urandom), PM_PLAIN));
    prog_q.push_back(imm_word(OP_SETR, 0, 10'd40));
    prog_q.push_back(encode(OP_LDX, 0, 0, PM_INC));
    prog_q.push_back(encode(OP_LDY, 0, 0, PM_PLAIN));
    prog_q.push_back(encode(OP_MAC, 0, 0, 0));
    prog_q.push_back(encode(OP_HALT, 0, 0, 0));
    execute_and_check("result with undefined word");
    report_test("fault", e0);
endtask

// ==== verification/dsp_core_tb.sv ====
`timescale 1ns/1ps
`include "dsp_config.svh"

module dsp_core_tb
    import dsp_isa_pkg::*;
    import dsp_host_pkg::*;
();

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  prog_req;
    prog_load_t            prog_word;
    logic                  prog_ack;
    logic                  run_req;
    logic                  run_ack;
    logic [`DSP_ACC_W-1:0] acc;
    logic                  fault;

    int checks = 0;
    int errors = 0;
    int tests  = 0;

    // Program words under construction
    logic [`DSP_INSTR_W-1:0] prog_q [$];

    // Reference model state kept across runs like the core
    logic [15:0]           ram_m [64];
    logic [5:0]            ptr_m [4];
    logic [5:0]            j_m;
    logic signed [15:0]    x_m;
    logic signed [15:0]    y_m;
    logic [`DSP_ACC_W-1:0] acc_m;
    logic                  fault_m;

    always #4 clk = ~clk;

    dsp_core DUT (
        .clk, .rst, .prog_req, .prog_word, .prog_ack, .run_req, .run_ack, .acc, .fault
    );

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic give_up(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic wait_prog_ack(input logic level);
        int n;
        n = 0;
        while (prog_ack !== level) begin
            next_cycle();
            n++;
            if (n > 20) give_up("Timeout waiting for prog_ack to change");
        end
    endtask

    task automatic wait_run_ack(input logic level);
        int n;
        n = 0;
        while (run_ack !== level) begin
            next_cycle();
            n++;
            if (n > 200) give_up("Timeout waiting for run_ack to change");
        end
    endtask

    // Four-phase write of every queued word from address 0
    task automatic load_program();
        compare(prog_ack, 1'b0, "prog_ack low before first req");
        for (int i = 0; i < prog_q.size(); i++) begin
            prog_word = {6'(i), prog_q[i]};
            prog_req  = 1'b1;
            wait_prog_ack(1'b1);
            prog_req = 1'b0;
            wait_prog_ack(1'b0);
        end
    endtask

    task automatic run_program(output logic [`DSP_ACC_W-1:0] result);
        compare(run_ack, 1'b0, "run_ack low before run_req");
        run_req = 1'b1;
        wait_run_ack(1'b1);
        result = acc;
        next_cycle();
        next_cycle();
        compare(run_ack, 1'b1, "run_ack held while run_req high");
        run_req = 1'b0;
        wait_run_ack(1'b0);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) $display("test %s: ok", name);
        else $display("test %s: %0d mismatches", name, errors - errs_before);
    endtask

    `include "dsp_core_tests.svh"

    initial begin
        void'($urandom(23));
        rst       = 1'b1;
        prog_req  = 1'b0;
        run_req   = 1'b0;
        prog_word = '0;
        for (int i = 0; i < 64; i++) ram_m[i] = '0;
        for (int i = 0; i < 4; i++) ptr_m[i] = '0;
        j_m     = '0;
        x_m     = '0;
        y_m     = '0;
        acc_m   = '0;
        fault_m = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        next_cycle();
        compare({prog_ack, run_ack, fault}, 3'b000, "outputs after reset");
        test_dot_product();
        test_pointer_modes();
        test_store_reuse();
        test_handshake();
        test_fault();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
